// ==== conv_top.f ====
+incdir+include
verilog/conv_pkg.sv
verilog/conv_line_buffer.sv
verilog/conv_window.sv
verilog/conv_position_ctrl.sv
verilog/conv_coeff_ram.sv
verilog/conv_mac.sv
verilog/conv_top.sv
verif/conv_clk_gen.sv
verif/conv_scoreboard.sv
verif/conv_chk.sv
verif/conv_tb.sv

// ==== include/conv_config.svh ====
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

////////////////////////////////////////
// engine geometry
////////////////////////////////////////

`define CONV_CHANNELS    2   // channels processed side by side
`define CONV_KERNEL      5   // window side
`define CONV_TAPS        25  // kernel squared, also the bias address
`define CONV_IMG_WIDTH   8   // square image, pixels per row and rows per frame

////////////////////////////////////////
// data widths
////////////////////////////////////////

`define CONV_PIXEL_BITS  8   // signed pixel
`define CONV_COEFF_BITS  8   // signed coefficient
`define CONV_ACC_BITS    24  // full precision sum of 25 products plus bias

// edges from pixel acceptance to out_valid, counting the accept edge
`define CONV_LATENCY     3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv_top regression with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_tb -f conv_top.f -o conv_sim

status=0
./obj_dir/conv_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log \
    || [ "$status" -ne 0 ]; then
    echo "simulation did not pass, see sim.log"
    exit 1
fi
echo "simulation passed"

// ==== verif/conv_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv_chk (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic coef_wr,
    input logic out_valid
);

    localparam int FRAME_PIX = `CONV_IMG_WIDTH * `CONV_IMG_WIDTH;

    int pix_cnt;  // pixels accepted in the current frame

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= 0;
        end else if (in_valid) begin
            pix_cnt <= (pix_cnt == FRAME_PIX - 1) ? 0 : pix_cnt + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while in reset");

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, `CONV_LATENCY))
        else $error("out_valid without a pixel accepted %0d edges before", `CONV_LATENCY);

    // writes only between frames, last window already past the bias stage
    a_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
        coef_wr |-> (pix_cnt == 0) && !in_valid && !$past(in_valid))
        else $error("coefficient write while a frame is in flight");

endmodule

bind conv_top conv_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .coef_wr   (coef_wr),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== verif/conv_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module conv_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // held low for 5 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/conv_scoreboard.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv_scoreboard (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  conv_pkg::pixel_vec_t in_data,
    input  logic                 coef_wr,
    input  conv_pkg::chan_idx_t  coef_chan,
    input  conv_pkg::tap_idx_t   coef_addr,
    input  conv_pkg::coeff_t     coef_data,
    input  logic                 out_valid,
    input  conv_pkg::acc_vec_t   out_data,
    output int                   frames_done,
    output int                   checks,
    output int                   errors
);

    localparam int K       = `CONV_KERNEL;
    localparam int W       = `CONV_IMG_WIDTH;
    localparam int WINDOWS = (W - K + 1) * (W - K + 1);

    int                 coef_m [`CONV_CHANNELS][`CONV_TAPS];
    int                 bias_m [`CONV_CHANNELS];
    int                 img_m [W][W][`CONV_CHANNELS];  // [row][col][channel]
    int                 row;
    int                 col;
    int                 frame_outs;
    int                 frame_errors;
    conv_pkg::acc_vec_t expect_q [$];

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    task automatic accept_pixel();
        conv_pkg::acc_vec_t expect_vec;
        int                 acc;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            img_m[row][col][ch] = conv_pkg::pixel_t'(in_data[ch]);
        end
        if (row >= K - 1 && col >= K - 1) begin
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                acc = bias_m[ch];
                for (int kr = 0; kr < K; kr++) begin
                    for (int kc = 0; kc < K; kc++) begin
                        acc += img_m[row-K+1+kr][col-K+1+kc][ch] * coef_m[ch][kr*K+kc];
                    end
                end
                expect_vec[ch] = conv_pkg::acc_t'(acc);
            end
            expect_q.push_back(expect_vec);
        end
        col = (col == W - 1) ? 0 : col + 1;  // raster order with wrap at frame end
        if (col == 0) begin
            row = (row == W - 1) ? 0 : row + 1;
        end
    endtask

    task automatic check_output();
        conv_pkg::acc_vec_t expect_vec;
        if (expect_q.size() == 0) begin
            $display("unexpected output at %0d ns, no complete window was pending", $time);
            errors++;
            return;
        end
        expect_vec = expect_q.pop_front();
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            if (out_data[ch] !== expect_vec[ch]) begin
                $display("mismatch at %0d ns: test %0d window %0d channel %0d got %0d expected %0d",
                         $time, frames_done, frame_outs, ch,
                         $signed(out_data[ch]), $signed(expect_vec[ch]));
                errors++;
                frame_errors++;
            end
        end
        checks++;
        frame_outs++;
        if (frame_outs == WINDOWS) begin
            $display("test %0d: %0d windows checked, %0d errors",
                     frames_done, WINDOWS, frame_errors);
            frames_done++;
            frame_outs   = 0;
            frame_errors = 0;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row         = 0;
            col         = 0;
            frame_outs  = 0;
            frame_errors = 0;
            frames_done = 0;
            checks      = 0;
            errors      = 0;
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                bias_m[ch] = 0;
                for (int t = 0; t < `CONV_TAPS; t++) begin
                    coef_m[ch][t] = 0;
                end
            end
        end else begin
            if (coef_wr && coef_addr < `CONV_TAPS) begin
                coef_m[coef_chan][coef_addr] = coef_data;
            end else if (coef_wr && coef_addr == `CONV_TAPS) begin
                bias_m[coef_chan] = coef_data;  // sign extended into the model
            end
            if (in_valid) begin
                accept_pixel();
            end
            if (out_valid) begin
                check_output();
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/conv_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv_tb;

    localparam int W         = `CONV_IMG_WIDTH;
    localparam int FRAME_PIX = W * W;
    localparam int WRITES    = `CONV_CHANNELS * (`CONV_TAPS + 1);  // taps plus bias
    localparam int CENTRE    = (`CONV_KERNEL / 2) * (`CONV_KERNEL + 1);

    typedef enum logic [1:0] {COEF_ZERO, COEF_CENTRE, COEF_ONES, COEF_RAND} coef_mode_e;
    typedef enum logic [1:0] {PIX_RAMP, PIX_CONST, PIX_RAND} pix_mode_e;

    typedef struct packed {
        coef_mode_e        coef_mode;
        logic signed [7:0] bias;     // channel 0, other channels get its inverse
        pix_mode_e         pix_mode;
        logic [6:0]        gap_pct;  // chance of an idle cycle before each pixel
    } test_row_t;

    localparam int NUM_TESTS = 7;
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{COEF_ZERO,   8'sd17,   PIX_RAMP,  7'd0},
        '{COEF_CENTRE, -8'sd5,   PIX_RAMP,  7'd0},
        '{COEF_ONES,   8'sd3,    PIX_CONST, 7'd0},
        '{COEF_RAND,   -8'sd100, PIX_RAND,  7'd0},
        '{COEF_RAND,   8'sd42,   PIX_RAND,  7'd40},
        '{COEF_CENTRE, 8'sd0,    PIX_RAND,  7'd25},
        '{COEF_ZERO,   -8'sd127, PIX_CONST, 7'd10}
    };

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    conv_pkg::pixel_vec_t in_data;
    logic                 coef_wr;
    conv_pkg::chan_idx_t  coef_chan;
    conv_pkg::tap_idx_t   coef_addr;
    conv_pkg::coeff_t     coef_data;
    logic                 out_valid;
    conv_pkg::acc_vec_t   out_data;
    int                   frames_done;
    int                   checks;
    int                   errors;
    int                   cycle_count = 0;
    integer               seed = 32'h66ad;

    conv_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    conv_top dut_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
        .coef_wr(coef_wr), .coef_chan(coef_chan), .coef_addr(coef_addr),
        .coef_data(coef_data), .out_valid(out_valid), .out_data(out_data)
    );

    conv_scoreboard sb_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
        .coef_wr(coef_wr), .coef_chan(coef_chan), .coef_addr(coef_addr),
        .coef_data(coef_data), .out_valid(out_valid), .out_data(out_data),
        .frames_done(frames_done), .checks(checks), .errors(errors)
    );

    ////////////////////////////////////////
    // drivers, 1 ns after the rising edge
    ////////////////////////////////////////

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        coef_wr  = 1'b0;
    endtask

    task automatic drive_write(input int chan, input int addr, input conv_pkg::coeff_t data);
        @(posedge clk);
        #1;
        coef_wr   = 1'b1;
        coef_chan = conv_pkg::chan_idx_t'(chan);
        coef_addr = conv_pkg::tap_idx_t'(addr);
        coef_data = data;
    endtask

    task automatic drive_pixel(input conv_pkg::pixel_vec_t pix);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_data  = pix;
    endtask

    task automatic load_coeffs(input coef_mode_e mode, input logic signed [7:0] bias);
        conv_pkg::coeff_t value;
        for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                case (mode)
                    COEF_ZERO:   value = '0;
                    COEF_CENTRE: value = (t == CENTRE) ? 8'sd1 : 8'sd0;
                    COEF_ONES:   value = 8'sd1;
                    default:     value = conv_pkg::coeff_t'($random(seed));
                endcase
                drive_write(ch, t, value);
            end
            drive_write(ch, `CONV_TAPS, (ch == 0) ? bias : ~bias);
        end
        drive_idle();
    endtask

    task automatic stream_frame(input pix_mode_e mode, input int gap_pct);
        conv_pkg::pixel_vec_t pix;
        int                   idx;
        for (idx = 0; idx < FRAME_PIX; idx++) begin
            while ({$random(seed)} % 100 < gap_pct) begin
                drive_idle();
            end
            for (int ch = 0; ch < `CONV_CHANNELS; ch++) begin
                case (mode)
                    PIX_RAMP:  pix[ch] = conv_pkg::pixel_t'((ch == 0) ? idx : 64 - 2 * idx);
                    PIX_CONST: pix[ch] = conv_pkg::pixel_t'((ch == 0) ? -7 : 5);
                    default:   pix[ch] = conv_pkg::pixel_t'($random(seed));
                endcase
            end
            drive_pixel(pix);
        end
        drive_idle();
    endtask

    // expected cycles per row, padded for gaps and drain, then doubled
    function automatic int timeout_cycles();
        int total;
        total = 20;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += FRAME_PIX * 100 / (100 - int'(TESTS[i].gap_pct)) + WRITES + 8;
        end
        return 2 * total;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles()) begin
            $display("timeout after %0d cycles, the DUT did not deliver every window", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        in_valid  = 1'b0;
        in_data   = '0;
        coef_wr   = 1'b0;
        coef_chan = '0;
        coef_addr = '0;
        coef_data = '0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < NUM_TESTS; i++) begin
            load_coeffs(TESTS[i].coef_mode, TESTS[i].bias);
            stream_frame(TESTS[i].pix_mode, int'(TESTS[i].gap_pct));
            while (frames_done < i + 1) begin
                @(posedge clk);
            end
        end
        repeat (4) @(posedge clk);  // room for a stray extra output
        $display("tests %0d, windows checked %0d, errors %0d", frames_done, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/conv_coeff_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv_coeff_ram (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                coef_wr,
    input  conv_pkg::chan_idx_t coef_chan,
    input  conv_pkg::tap_idx_t  coef_addr,
    input  conv_pkg::coeff_t    coef_data,
    output conv_pkg::coeff_t    coeffs [`CONV_CHANNELS][`CONV_TAPS],
    output conv_pkg::acc_t      biases [`CONV_CHANNELS]
);

    localparam conv_pkg::tap_idx_t BIAS_ADDR = conv_pkg::tap_idx_t'(`CONV_TAPS);
    localparam int EXT_BITS = `CONV_ACC_BITS - `CONV_COEFF_BITS;

    conv_pkg::acc_t bias_ext;

    // bias written through the coefficient port, widened with its sign
    assign bias_ext = {{EXT_BITS{coef_data[`CONV_COEFF_BITS-1]}}, coef_data};

    ////////////////////////////////////////
    // storage, one write per cycle
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < `CONV_CHANNELS; c++) begin
                biases[c] <= '0;
                for (int t = 0; t < `CONV_TAPS; t++) begin
                    coeffs[c][t] <= '0;
                end
            end
        end else if (coef_wr) begin
            if (coef_addr < BIAS_ADDR) begin
                coeffs[coef_chan][coef_addr] <= coef_data;
            end else if (coef_addr == BIAS_ADDR) begin
                biases[coef_chan] <= bias_ext;
            end
            // anything above the bias address is dropped
        end
    end

endmodule

`default_nettype wire

// ==== verilog/conv_line_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

// one image row of delay, moves only on accepted pixels
module conv_line_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 shift_en,
    input  conv_pkg::pixel_vec_t din,
    output conv_pkg::pixel_vec_t dout
);

    conv_pkg::pixel_vec_t taps [`CONV_IMG_WIDTH];  // taps[0] newest

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CONV_IMG_WIDTH; i++) begin
                taps[i] <= '0;
            end
        end else if (shift_en) begin
            taps[0] <= din;
            for (int i = 1; i < `CONV_IMG_WIDTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // same column, previous row
    assign dout = taps[`CONV_IMG_WIDTH-1];

endmodule

`default_nettype wire

// ==== verilog/conv_mac.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

// per-channel dot product of window and kernel, plus bias
module conv_mac (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 win_valid,
    input  conv_pkg::pixel_vec_t window [`CONV_TAPS],
    input  conv_pkg::coeff_t     coeffs [`CONV_CHANNELS][`CONV_TAPS],
    input  conv_pkg::acc_t       biases [`CONV_CHANNELS],
    output logic                 out_valid,
    output conv_pkg::acc_vec_t   out_data
);

    conv_pkg::prod_t prod_q [`CONV_CHANNELS][`CONV_TAPS];
    logic            prod_valid;
    conv_pkg::acc_t  sum [`CONV_CHANNELS];

    ////////////////////////////////////////
    // stage 1, tap products
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int c = 0; c < `CONV_CHANNELS; c++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                // both operands signed, widened to the product size first
                prod_q[c][t] <= conv_pkg::pixel_t'(window[t][c]) * coeffs[c][t];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= win_valid;
        end
    end

    ////////////////////////////////////////
    // stage 2, adder tree and bias
    ////////////////////////////////////////

    // no saturation, the accumulator holds the worst case
    always_comb begin
        for (int c = 0; c < `CONV_CHANNELS; c++) begin
            sum[c] = biases[c];
            for (int t = 0; t < `CONV_TAPS; t++) begin
                sum[c] = sum[c] + conv_pkg::acc_t'(prod_q[c][t]);  // sign extend
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int c = 0; c < `CONV_CHANNELS; c++) begin
                out_data[c] <= sum[c];
            end
        end
    end

    // one cycle pulse per finished window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/conv_pkg.sv ====
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

    ////////////////////////////////////////
    // datapath types
    ////////////////////////////////////////

    typedef logic signed [`CONV_PIXEL_BITS-1:0] pixel_t;
    typedef pixel_t [`CONV_CHANNELS-1:0] pixel_vec_t;  // one pixel per channel

    typedef logic signed [`CONV_COEFF_BITS-1:0] coeff_t;
    typedef logic signed [`CONV_PIXEL_BITS+`CONV_COEFF_BITS-1:0] prod_t;

    typedef logic signed [`CONV_ACC_BITS-1:0] acc_t;
    typedef acc_t [`CONV_CHANNELS-1:0] acc_vec_t;  // one result per channel

    ////////////////////////////////////////
    // addresses and counters
    ////////////////////////////////////////

    // taps are row * kernel + column, CONV_TAPS selects the bias
    typedef logic [$clog2(`CONV_TAPS+1)-1:0] tap_idx_t;
    typedef logic [$clog2(`CONV_CHANNELS)-1:0] chan_idx_t;
    typedef logic [$clog2(`CONV_IMG_WIDTH)-1:0] coord_t;

endpackage

`default_nettype wire

// ==== verilog/conv_position_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

// tracks where the next pixel lands in the frame
module conv_position_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic win_valid
);

    localparam conv_pkg::coord_t LAST_POS = conv_pkg::coord_t'(`CONV_IMG_WIDTH - 1);
    localparam conv_pkg::coord_t FIRST_WIN = conv_pkg::coord_t'(`CONV_KERNEL - 1);

    conv_pkg::coord_t col;  // column of the next pixel
    conv_pkg::coord_t row;  // row of the next pixel
    logic             row_end;
    logic             win_done;

    assign row_end = (col == LAST_POS);

    // enough rows and columns seen for a full window
    assign win_done = (row >= FIRST_WIN) && (col >= FIRST_WIN);

    ////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (in_valid) begin
            if (row_end) begin
                col <= '0;
                row <= (row == LAST_POS) ? '0 : row + 1'b1;  // wrap at frame end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // lines up with the window register update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= in_valid && win_done;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/conv_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  conv_pkg::pixel_vec_t in_data,
    input  logic                 coef_wr,
    input  conv_pkg::chan_idx_t  coef_chan,
    input  conv_pkg::tap_idx_t   coef_addr,
    input  conv_pkg::coeff_t     coef_data,
    output logic                 out_valid,
    output conv_pkg::acc_vec_t   out_data
);

    logic                 win_valid;                             // window holds a full tile
    conv_pkg::pixel_vec_t window [`CONV_TAPS];
    conv_pkg::coeff_t     coeffs [`CONV_CHANNELS][`CONV_TAPS];
    conv_pkg::acc_t       biases [`CONV_CHANNELS];

    ////////////////////////////////////////
    // producer side
    ////////////////////////////////////////

    conv_position_ctrl pos_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .win_valid (win_valid)
    );

    conv_window window_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .window   (window)
    );

    ////////////////////////////////////////
    // consumer side
    ////////////////////////////////////////

    // loaded between frames only
    conv_coeff_ram coeff_ram_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .coef_wr   (coef_wr),
        .coef_chan (coef_chan),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .coeffs    (coeffs),
        .biases    (biases)
    );

    conv_mac mac_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .window    (window),
        .coeffs    (coeffs),
        .biases    (biases),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== verilog/conv_window.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "conv_config.svh"

module conv_window (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  conv_pkg::pixel_vec_t in_data,
    output conv_pkg::pixel_vec_t window [`CONV_TAPS]
);

    ////////////////////////////////////////
    // incoming column
    ////////////////////////////////////////

    // row_tap[KERNEL-1] is the live pixel, row_tap[0] is four rows back
    conv_pkg::pixel_vec_t row_tap [`CONV_KERNEL];

    assign row_tap[`CONV_KERNEL-1] = in_data;

    genvar k;
    generate
        for (k = 0; k < `CONV_KERNEL - 1; k++) begin : g_line
            conv_line_buffer line_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .shift_en (in_valid),
                .din      (row_tap[`CONV_KERNEL-1-k]),
                .dout     (row_tap[`CONV_KERNEL-2-k])
            );
        end
    endgenerate

    ////////////////////////////////////////
    // window shift register
    ////////////////////////////////////////

    // new column enters at the right, column 0 falls out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                window[t] <= '0;
            end
        end else if (in_valid) begin
            for (int r = 0; r < `CONV_KERNEL; r++) begin
                for (int c = 0; c < `CONV_KERNEL - 1; c++) begin
                    window[r*`CONV_KERNEL+c] <= window[r*`CONV_KERNEL+c+1];
                end
                window[r*`CONV_KERNEL+`CONV_KERNEL-1] <= row_tap[r];  // newest column
            end
        end
    end

endmodule

`default_nettype wire
